/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_safe_domain
RTL_TOP   ?= safe_domain
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint lint_rtl sim clean

all: sim

lint: lint_rtl
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

lint_rtl:
	$(VERILATOR) --lint-only -Irtl rtl/pad_pkg.sv rtl/safe_ctrl_pkg.sv \
		rtl/safe_clk_div.sv rtl/safe_rst_seq.sv rtl/safe_pad_mux.sv \
		rtl/safe_domain.sv --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
+incdir+rtl
rtl/pad_pkg.sv
rtl/safe_ctrl_pkg.sv
rtl/safe_clk_div.sv
rtl/safe_rst_seq.sv
rtl/safe_pad_mux.sv
rtl/safe_domain.sv
tb/safe_domain_asserts.sv
tb/tb_safe_domain.sv

/* rtl/pad_pkg.sv */
`default_nettype none

`include "safe_defs.svh"

package pad_pkg;

  // pad mux select, one per pad
  typedef enum logic [`NBIT_PADMUX-1:0] {
    SEL_PERIO  = 2'd0,
    SEL_APBIO  = 2'd1,
    SEL_FPGAIO = 2'd2,
    SEL_NONE   = 2'd3
  } pad_sel_e;

  // drive of one peripheral group, also used for the pad drive itself
  typedef struct packed {
    logic [`N_IO-1:0] out;
    logic [`N_IO-1:0] oe;
  } pad_bus_t;

  // config word while the pad drives
  // drive strength takes what slew and odrain leave
  typedef struct packed {
    logic [`NBIT_PADCFG-3:0] drive;
    logic                    slew;
    logic                    odrain;
  } pad_out_cfg_t;

  // config word while the pad receives
  typedef struct packed {
    logic pull_up;
    logic pull_dn;
    logic schmitt;
    logic keeper;
  } pad_in_cfg_t;

  // same word, decoded by pad direction
  typedef union packed {
    pad_out_cfg_t out_v;
    pad_in_cfg_t  in_v;
  } pad_cfg_u;

  // safe input state, pulled down and nothing else
  localparam pad_in_cfg_t PAD_SAFE_IN = '{pull_up: 1'b0, pull_dn: 1'b1,
                                         schmitt: 1'b0, keeper: 1'b0};
  localparam pad_cfg_u PAD_SAFE_CFG = pad_cfg_u'(PAD_SAFE_IN);

endpackage

`default_nettype wire

/* rtl/safe_clk_div.sv */
`timescale 1ns/1ns
`default_nettype none

`include "safe_defs.svh"

module safe_clk_div (
  input  logic                     ref_clk_i,
  input  logic                     rst_n_i,
  output logic                     slow_clk_o,
  output logic                     efpga_clk_o,
  output safe_ctrl_pkg::clk_stat_t stat_o
);

  localparam int HALF  = `SLOW_DIV / 2;
  localparam int CNT_W = $clog2(HALF + 1);

  logic [CNT_W-1:0] cnt_q;
  logic             wrap;
  // first half period after reset is held low
  logic             started_q;
  logic             slow_q;
  logic             efpga_q;
  logic             tick_q;

  // end of a half slow period
  assign wrap = (cnt_q == CNT_W'(HALF - 1));

  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q     <= '0;
      started_q <= 1'b0;
      slow_q    <= 1'b0;
      efpga_q   <= 1'b0;
      tick_q    <= 1'b0;
    end else begin
      // efpga clock is ref / 2
      efpga_q <= ~efpga_q;
      cnt_q   <= wrap ? '0 : cnt_q + 1'b1;
      if (wrap) begin
        started_q <= 1'b1;
      end
      if (wrap && started_q) begin
        slow_q <= ~slow_q;
      end
      // rising slow edge, lines up with slow_q going high
      tick_q <= wrap && started_q && !slow_q;
    end
  end

  assign slow_clk_o       = slow_q;
  assign efpga_clk_o      = efpga_q;
  assign stat_o.slow_tick = tick_q;

endmodule

`default_nettype wire

/* rtl/safe_ctrl_pkg.sv */
`default_nettype none

package safe_ctrl_pkg;

  // soc reset sequencer
  typedef enum logic [1:0] {
    ST_HOLD   = 2'd0,
    ST_SETTLE = 2'd1,
    ST_RUN    = 2'd2
  } rst_state_e;

  // status from the clock divider, all in the ref clock domain
  typedef struct packed {
    // one ref cycle wide, in the cycle the slow clock rises
    logic slow_tick;
  } clk_stat_t;

endpackage

`default_nettype wire

/* rtl/safe_defs.svh */
`ifndef SAFE_DEFS_SVH
`define SAFE_DEFS_SVH

// ************************************************************
// pad ring dimensions
// ************************************************************

// pads handled by the safe domain
// every peripheral group (perio, apbio, fpgaio) has one bit per pad
`define N_IO 8

// mux select per pad
`define NBIT_PADMUX 2

// pad config word per pad
`define NBIT_PADCFG 4

// ************************************************************
// clocking and reset release
// ************************************************************

// ref cycles per slow clock period, keep even
`define SLOW_DIV 8

// slow clock rising edges to wait before soc reset release
`define SETTLE_TICKS 4

`endif

/* rtl/safe_domain.sv */
`timescale 1ns/1ns
`default_nettype none

`include "safe_defs.svh"

module safe_domain (
  input  logic                          ref_clk_i,
  input  logic                          rst_n_i,
  output logic                          slow_clk_o,
  output logic                          efpga_clk_o,
  output logic                          rst_no,

  // ************************************************************
  // pad control
  // ************************************************************

  input  pad_pkg::pad_sel_e [`N_IO-1:0] pad_sel_i,
  input  pad_pkg::pad_cfg_u [`N_IO-1:0] pad_cfg_i,
  output pad_pkg::pad_cfg_u [`N_IO-1:0] pad_cfg_o,

  // pads
  input  logic              [`N_IO-1:0] io_in_i,
  output pad_pkg::pad_bus_t             pad_o,

  // ************************************************************
  // peripheral groups
  // ************************************************************

  input  pad_pkg::pad_bus_t             perio_i,
  output logic              [`N_IO-1:0] perio_in_o,
  input  pad_pkg::pad_bus_t             apbio_i,
  output logic              [`N_IO-1:0] apbio_in_o,
  input  pad_pkg::pad_bus_t             fpgaio_i,
  output logic              [`N_IO-1:0] fpgaio_in_o
);

  safe_ctrl_pkg::clk_stat_t clk_stat;
  // pads follow the mux only once the soc is out of reset
  logic                     pads_en;

  // slow and efpga clocks, slow edge tick
  safe_clk_div i_clk_div (
    .ref_clk_i  (ref_clk_i),
    .rst_n_i    (rst_n_i),
    .slow_clk_o (slow_clk_o),
    .efpga_clk_o(efpga_clk_o),
    .stat_o     (clk_stat)
  );

  // soc reset release after the slow clock has settled
  safe_rst_seq i_rst_seq (
    .ref_clk_i(ref_clk_i),
    .rst_n_i  (rst_n_i),
    .stat_i   (clk_stat),
    .rst_no   (rst_no),
    .pads_en_o(pads_en)
  );

  safe_pad_mux i_pad_mux (
    .ref_clk_i  (ref_clk_i),
    .rst_n_i    (rst_n_i),
    .pads_en_i  (pads_en),
    .pad_sel_i  (pad_sel_i),
    .pad_cfg_i  (pad_cfg_i),
    .pad_cfg_o  (pad_cfg_o),
    .perio_i    (perio_i),
    .apbio_i    (apbio_i),
    .fpgaio_i   (fpgaio_i),
    .perio_in_o (perio_in_o),
    .apbio_in_o (apbio_in_o),
    .fpgaio_in_o(fpgaio_in_o),
    .io_in_i    (io_in_i),
    .pad_o      (pad_o)
  );

endmodule

`default_nettype wire

/* rtl/safe_pad_mux.sv */
`timescale 1ns/1ns
`default_nettype none

`include "safe_defs.svh"

module safe_pad_mux (
  input  logic                                ref_clk_i,
  input  logic                                rst_n_i,
  input  logic                                pads_en_i,
  input  pad_pkg::pad_sel_e [`N_IO-1:0]       pad_sel_i,
  input  pad_pkg::pad_cfg_u [`N_IO-1:0]       pad_cfg_i,
  output pad_pkg::pad_cfg_u [`N_IO-1:0]       pad_cfg_o,
  input  pad_pkg::pad_bus_t                   perio_i,
  input  pad_pkg::pad_bus_t                   apbio_i,
  input  pad_pkg::pad_bus_t                   fpgaio_i,
  output logic              [`N_IO-1:0]       perio_in_o,
  output logic              [`N_IO-1:0]       apbio_in_o,
  output logic              [`N_IO-1:0]       fpgaio_in_o,
  input  logic              [`N_IO-1:0]       io_in_i,
  output pad_pkg::pad_bus_t                   pad_o
);

  logic [`N_IO-1:0]     out_sel;
  logic [`N_IO-1:0]     oe_sel;
  pad_pkg::pad_bus_t    pad_q;
  pad_pkg::pad_in_cfg_t in_cfg;

  // ************************************************************
  // routing, drive out and input back per pad
  // ************************************************************

  always_comb begin
    out_sel     = '0;
    oe_sel      = '0;
    perio_in_o  = '0;
    apbio_in_o  = '0;
    fpgaio_in_o = '0;
    for (int k = 0; k < `N_IO; k++) begin
      case (pad_sel_i[k])
        pad_pkg::SEL_PERIO: begin
          out_sel[k]    = perio_i.out[k];
          oe_sel[k]     = perio_i.oe[k];
          perio_in_o[k] = io_in_i[k];
        end
        pad_pkg::SEL_APBIO: begin
          out_sel[k]    = apbio_i.out[k];
          oe_sel[k]     = apbio_i.oe[k];
          apbio_in_o[k] = io_in_i[k];
        end
        pad_pkg::SEL_FPGAIO: begin
          out_sel[k]     = fpgaio_i.out[k];
          oe_sel[k]      = fpgaio_i.oe[k];
          fpgaio_in_o[k] = io_in_i[k];
        end
        // unrouted pad, no drive and no input return
        default: begin
          out_sel[k] = 1'b0;
          oe_sel[k]  = 1'b0;
        end
      endcase
    end
  end

  // registered pad drive, held off until release
  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pad_q <= '0;
    end else begin
      pad_q.out <= pads_en_i ? out_sel : '0;
      pad_q.oe  <= pads_en_i ? oe_sel : '0;
    end
  end

  assign pad_o = pad_q;

  // ************************************************************
  // config word, decoded by pad direction
  // ************************************************************

  always_comb begin
    in_cfg    = '0;
    pad_cfg_o = '0;
    for (int k = 0; k < `N_IO; k++) begin
      in_cfg = pad_cfg_i[k].in_v;
      // both pulls set, pull down wins
      if (in_cfg.pull_dn) begin
        in_cfg.pull_up = 1'b0;
      end
      if (!pads_en_i || (pad_sel_i[k] == pad_pkg::SEL_NONE)) begin
        pad_cfg_o[k] = pad_pkg::PAD_SAFE_CFG;
      end else if (oe_sel[k]) begin
        // driving pad, output view as given
        pad_cfg_o[k].out_v = pad_cfg_i[k].out_v;
      end else begin
        pad_cfg_o[k].in_v = in_cfg;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/safe_rst_seq.sv */
`timescale 1ns/1ns
`default_nettype none

`include "safe_defs.svh"

module safe_rst_seq (
  input  logic                     ref_clk_i,
  input  logic                     rst_n_i,
  input  safe_ctrl_pkg::clk_stat_t stat_i,
  output logic                     rst_no,
  output logic                     pads_en_o
);

  localparam int CNT_W = $clog2(`SETTLE_TICKS + 1);

  safe_ctrl_pkg::rst_state_e state_q;
  safe_ctrl_pkg::rst_state_e state_d;
  logic [CNT_W-1:0]          tick_cnt_q;
  logic [CNT_W-1:0]          tick_cnt_d;
  logic                      last_tick;
  logic                      run_q;

  // settle period ends on this slow edge
  assign last_tick = stat_i.slow_tick && (tick_cnt_q == CNT_W'(`SETTLE_TICKS - 1));

  // ************************************************************
  // next state
  // ************************************************************

  always_comb begin
    state_d    = state_q;
    tick_cnt_d = tick_cnt_q;
    case (state_q)
      safe_ctrl_pkg::ST_HOLD: begin
        tick_cnt_d = '0;
        state_d    = safe_ctrl_pkg::ST_SETTLE;
      end
      safe_ctrl_pkg::ST_SETTLE: begin
        if (last_tick) begin
          state_d = safe_ctrl_pkg::ST_RUN;
        end else if (stat_i.slow_tick) begin
          tick_cnt_d = tick_cnt_q + 1'b1;
        end
      end
      // stays here until the next rst_n_i
      safe_ctrl_pkg::ST_RUN: begin
        state_d = safe_ctrl_pkg::ST_RUN;
      end
      default: begin
        state_d = safe_ctrl_pkg::ST_HOLD;
      end
    endcase
  end

  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= safe_ctrl_pkg::ST_HOLD;
      tick_cnt_q <= '0;
      run_q      <= 1'b0;
    end else begin
      state_q    <= state_d;
      tick_cnt_q <= tick_cnt_d;
      // high exactly while in ST_RUN
      run_q      <= (state_d == safe_ctrl_pkg::ST_RUN);
    end
  end

  // soc reset and pad enable release together
  assign rst_no    = run_q;
  assign pads_en_o = run_q;

endmodule

`default_nettype wire

/* tb/safe_domain_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

`include "safe_defs.svh"

module safe_domain_asserts #(
  parameter bit CHECK_PADS = 1'b0,
  parameter bit CHECK_SEQ  = 1'b0
) (
  input logic                     clk_i,
  input logic                     rst_n_i,
  input logic                     pads_en_i,
  input pad_pkg::pad_bus_t        pad_i,
  input logic                     rst_no_i,
  input safe_ctrl_pkg::clk_stat_t stat_i
);

  // ************************************************************
  // pad safety, only in the pad mux binding
  // ************************************************************
  if (CHECK_PADS) begin : g_pads
    // no pad may drive before release
    a_pads_off : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !pads_en_i |-> (pad_i.oe == '0))
      else $error("pad output enable set while pads are disabled");
  end

  // ************************************************************
  // reset sequencer and slow tick
  // ************************************************************
  if (CHECK_SEQ) begin : g_seq
    // soc reset only drops with the board reset
    a_rst_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !$fell(rst_no_i))
      else $error("rst_no fell while rst_n_i was high");
    // tick is a single ref cycle pulse
    a_tick_pulse : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      stat_i.slow_tick |=> !stat_i.slow_tick)
      else $error("slow_tick high on two consecutive cycles");
  end

endmodule

bind safe_pad_mux safe_domain_asserts #(.CHECK_PADS(1'b1), .CHECK_SEQ(1'b0)) pad_chk_i (
  .clk_i    (ref_clk_i),
  .rst_n_i  (rst_n_i),
  .pads_en_i(pads_en_i),
  .pad_i    (pad_o),
  .rst_no_i (1'b0),
  .stat_i   (1'b0)
);

bind safe_rst_seq safe_domain_asserts #(.CHECK_PADS(1'b0), .CHECK_SEQ(1'b1)) seq_chk_i (
  .clk_i    (ref_clk_i),
  .rst_n_i  (rst_n_i),
  .pads_en_i(1'b0),
  .pad_i    ('0),
  .rst_no_i (rst_no),
  .stat_i   (stat_i)
);

`default_nettype wire

/* tb/safe_trace.txt */
# sel cfg perio apbio fpgaio io_in | exp: pad_o cfg_o perio_in apbio_in fpgaio_in
# all hex, pad 0 in the low bits, bus words are {out, oe}
0000 C3A5C3A5 A5FF 0000 0000 3C A5FF C3A5C3A5 3C 00 00
5555 CCCCCCCC A5FF 0F00 0000 81 0F00 44444444 00 81 00
AAAA EEEEEEEE A5FF 0F00 33F0 FF 33F0 EEEE6666 00 00 FF
FFFF 12345678 A5FF 0F00 33F0 FF 0000 44444444 00 00 00
E4E4 DDDDDDDD FF01 0022 4400 5A 5523 45D545DD 10 02 40
0000 00000000 0000 0000 0000 00 0000 00000000 00 00 00
9999 F0F0F0F0 1234 FF55 0000 F0 5555 70707070 00 50 A0

/* tb/tb_safe_domain.sv */
`timescale 1ns/1ns
`default_nettype none

`include "safe_defs.svh"

module tb_safe_domain;

  typedef pad_pkg::pad_sel_e [`N_IO-1:0] sel_arr_t;
  typedef pad_pkg::pad_cfg_u [`N_IO-1:0] cfg_arr_t;

  // one trace line with stimulus then expected values
  typedef struct packed {
    logic [2*`N_IO-1:0] sel;
    logic [4*`N_IO-1:0] cfg;
    pad_pkg::pad_bus_t  perio;
    pad_pkg::pad_bus_t  apbio;
    pad_pkg::pad_bus_t  fpgaio;
    logic [`N_IO-1:0]   io_in;
    pad_pkg::pad_bus_t  exp_pad;
    logic [4*`N_IO-1:0] exp_cfg;
    logic [`N_IO-1:0]   exp_perio;
    logic [`N_IO-1:0]   exp_apbio;
    logic [`N_IO-1:0]   exp_fpgaio;
  } trace_vec_t;

  localparam int RELEASE_CYCLES = `SLOW_DIV * `SETTLE_TICKS + 1;
  localparam int WAIT_LIMIT     = 200;

  logic              ref_clk;
  logic              rst_n;
  logic              slow_clk;
  logic              efpga_clk;
  logic              rst_no;
  sel_arr_t          pad_sel;
  cfg_arr_t          pad_cfg;
  cfg_arr_t          pad_cfg_out;
  logic [`N_IO-1:0]  io_in;
  pad_pkg::pad_bus_t pad;
  pad_pkg::pad_bus_t perio;
  pad_pkg::pad_bus_t apbio;
  pad_pkg::pad_bus_t fpgaio;
  logic [`N_IO-1:0]  perio_in;
  logic [`N_IO-1:0]  apbio_in;
  logic [`N_IO-1:0]  fpgaio_in;

  trace_vec_t vecs[$];
  int         err_cnt;
  int         test_cnt;
  int         test_fail;
  int         test_err_start;

  safe_domain dut_i (
    .ref_clk_i  (ref_clk),
    .rst_n_i    (rst_n),
    .slow_clk_o (slow_clk),
    .efpga_clk_o(efpga_clk),
    .rst_no     (rst_no),
    .pad_sel_i  (pad_sel),
    .pad_cfg_i  (pad_cfg),
    .pad_cfg_o  (pad_cfg_out),
    .io_in_i    (io_in),
    .pad_o      (pad),
    .perio_i    (perio),
    .perio_in_o (perio_in),
    .apbio_i    (apbio),
    .apbio_in_o (apbio_in),
    .fpgaio_i   (fpgaio),
    .fpgaio_in_o(fpgaio_in)
  );

  // 8 ns ref clock
  always #4 ref_clk = ~ref_clk;

  // ************************************************************
  // compare tasks
  // ************************************************************

  task automatic check_bus(input string name, input pad_pkg::pad_bus_t exp,
                           input pad_pkg::pad_bus_t act);
    if (act !== exp) begin
      err_cnt++;
      $display("ERR %0t %s exp=%h act=%h", $time, name, exp, act);
    end
  endtask

  task automatic check_cfg(input string name, input cfg_arr_t exp, input cfg_arr_t act);
    if (act !== exp) begin
      err_cnt++;
      $display("ERR %0t %s exp=%h act=%h", $time, name, exp, act);
    end
  endtask

  task automatic check_vec(input string name, input logic [`N_IO-1:0] exp,
                           input logic [`N_IO-1:0] act);
    if (act !== exp) begin
      err_cnt++;
      $display("ERR %0t %s exp=%h act=%h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      err_cnt++;
      $display("ERR %0t %s exp=%b act=%b", $time, name, exp, act);
    end
  endtask

  // ************************************************************
  // helpers
  // ************************************************************

  // every pad word in the safe input state
  function automatic cfg_arr_t safe_cfg_arr();
    cfg_arr_t a;
    for (int k = 0; k < `N_IO; k++) begin
      a[k] = pad_pkg::PAD_SAFE_CFG;
    end
    return a;
  endfunction

  function automatic logic clk_level(input bit use_slow);
    return use_slow ? slow_clk : efpga_clk;
  endfunction

  task automatic end_test(input string name);
    test_cnt++;
    if (err_cnt > test_err_start) begin
      test_fail++;
      $display("test %s: FAIL, %0d errors", name, err_cnt - test_err_start);
    end else begin
      $display("test %s: ok", name);
    end
    test_err_start = err_cnt;
  endtask

  task automatic load_trace();
    int    fd;
    int    n;
    string line;
    logic [31:0] f[11];
    trace_vec_t  v;
    fd = $fopen("tb/safe_trace.txt", "r");
    if (fd == 0) begin
      err_cnt++;
      $display("could not open the trace file tb/safe_trace.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      // skip comments and blank lines
      if (line.len() < 2 || line.substr(0, 0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                  f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
      if (n != 11) begin
        err_cnt++;
        $display("trace line has %0d fields instead of 11", n);
        continue;
      end
      v.sel        = f[0][2*`N_IO-1:0];
      v.cfg        = f[1];
      v.perio      = f[2][2*`N_IO-1:0];
      v.apbio      = f[3][2*`N_IO-1:0];
      v.fpgaio     = f[4][2*`N_IO-1:0];
      v.io_in      = f[5][`N_IO-1:0];
      v.exp_pad    = f[6][2*`N_IO-1:0];
      v.exp_cfg    = f[7];
      v.exp_perio  = f[8][`N_IO-1:0];
      v.exp_apbio  = f[9][`N_IO-1:0];
      v.exp_fpgaio = f[10][`N_IO-1:0];
      vecs.push_back(v);
    end
    $fclose(fd);
    if (vecs.size() == 0) begin
      err_cnt++;
      $display("the trace file holds no vectors");
    end
  endtask

  // call right after a rising edge
  task automatic drive_vec(input trace_vec_t v);
    pad_sel <= sel_arr_t'(v.sel);
    pad_cfg <= cfg_arr_t'(v.cfg);
    perio   <= v.perio;
    apbio   <= v.apbio;
    fpgaio  <= v.fpgaio;
    io_in   <= v.io_in;
  endtask

  // held state checked away from the clock edge
  task automatic check_held();
    check_bit("rst_no", 1'b0, rst_no);
    check_bit("slow_clk_o", 1'b0, slow_clk);
    check_bit("efpga_clk_o", 1'b0, efpga_clk);
    check_bus("pad_o", '0, pad);
    check_cfg("pad_cfg_o", safe_cfg_arr(), pad_cfg_out);
  endtask

  // release on a rising edge and count ref cycles until rst_no
  task automatic release_and_count();
    int  cycles;
    bit  seen;
    seen = 1'b0;
    @(posedge ref_clk);
    rst_n <= 1'b1;
    for (cycles = 0; cycles <= WAIT_LIMIT; cycles++) begin
      @(negedge ref_clk);
      if (rst_no) begin
        seen = 1'b1;
        break;
      end
      // pads stay safe during settle
      check_bus("pad_o", '0, pad);
      check_cfg("pad_cfg_o", safe_cfg_arr(), pad_cfg_out);
    end
    if (!seen) begin
      err_cnt++;
      $display("timeout waiting for rst_no to rise after reset release");
    end else if (cycles != RELEASE_CYCLES) begin
      err_cnt++;
      $display("ERR %0t release_cycles exp=%0d act=%0d", $time, RELEASE_CYCLES, cycles);
    end
  endtask

  // ref cycles between two rising edges of the chosen clock
  task automatic measure_period(input bit use_slow, output int cycles, output bit ok);
    logic prev;
    logic cur;
    bit   seen;
    ok     = 1'b0;
    seen   = 1'b0;
    cycles = 0;
    prev   = clk_level(use_slow);
    for (int n = 0; n < 4 * `SLOW_DIV; n++) begin
      @(negedge ref_clk);
      cur = clk_level(use_slow);
      if (seen) begin
        cycles++;
      end
      if (!prev && cur) begin
        if (seen) begin
          ok = 1'b1;
          break;
        end
        seen = 1'b1;
      end
      prev = cur;
    end
  endtask

  task automatic check_clock(input bit use_slow, input string name, input int exp);
    int cycles;
    bit ok;
    for (int i = 0; i < 3; i++) begin
      measure_period(use_slow, cycles, ok);
      if (!ok) begin
        err_cnt++;
        $display("timeout waiting for two rising edges of %s", name);
      end else if (cycles != exp) begin
        err_cnt++;
        $display("ERR %0t %s_period exp=%0d act=%0d", $time, name, exp, cycles);
      end
    end
  endtask

  // comb results checked in the drive cycle and pad drive one cycle later
  task automatic check_routing(input trace_vec_t v);
    @(posedge ref_clk);
    drive_vec(v);
    @(negedge ref_clk);
    check_cfg("pad_cfg_o", cfg_arr_t'(v.exp_cfg), pad_cfg_out);
    check_vec("perio_in_o", v.exp_perio, perio_in);
    check_vec("apbio_in_o", v.exp_apbio, apbio_in);
    check_vec("fpgaio_in_o", v.exp_fpgaio, fpgaio_in);
    @(negedge ref_clk);
    check_bus("pad_o", v.exp_pad, pad);
  endtask

  // ************************************************************
  // main sequence
  // ************************************************************

  initial begin
    ref_clk        = 1'b0;
    rst_n          = 1'b0;
    pad_sel        = sel_arr_t'('0);
    pad_cfg        = '0;
    io_in          = '0;
    perio          = '0;
    apbio          = '0;
    fpgaio         = '0;
    err_cnt        = 0;
    test_cnt       = 0;
    test_fail      = 0;
    test_err_start = 0;

    load_trace();
    end_test("trace_load");

    // stimulus already applied while in reset
    if (vecs.size() > 0) begin
      @(posedge ref_clk);
      drive_vec(vecs[0]);
    end
    repeat (8) @(posedge ref_clk);
    @(negedge ref_clk);
    check_held();
    end_test("reset_state");

    release_and_count();
    end_test("release_timing");

    check_clock(1'b1, "slow_clk_o", `SLOW_DIV);
    check_clock(1'b0, "efpga_clk_o", 2);
    end_test("clock_ratio");

    foreach (vecs[i]) begin
      check_routing(vecs[i]);
    end
    end_test("routing_and_config");

    // reset again in the middle of a run
    @(posedge ref_clk);
    rst_n <= 1'b0;
    @(negedge ref_clk);
    check_held();
    repeat (7) @(posedge ref_clk);
    @(negedge ref_clk);
    check_held();
    end_test("mid_run_reset");

    release_and_count();
    if (vecs.size() > 0) begin
      check_routing(vecs[0]);
    end
    end_test("second_release");

    $display("tests %0d, failed %0d, errors %0d", test_cnt, test_fail, err_cnt);
    if (err_cnt == 0 && test_fail == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
